// ==== logic/egress_config.svh ====
/* Egress stage constants */

`ifndef EGRESS_CONFIG_SVH
`define EGRESS_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Port layout

`define EGRESS_NUM_PORTS     4
// Ports below this index are narrow, the rest are wide
`define EGRESS_NUM_NARROW    2

//////////////////////////////////////////////////////////////////////
// Data widths in bytes

`define EGRESS_WORD_BYTES    8
`define EGRESS_NARROW_BYTES  1
`define EGRESS_WIDE_BYTES    4

// Per-port word buffer and largest packet
`define EGRESS_FIFO_DEPTH    16
`define EGRESS_MTU_BYTES     256

//////////////////////////////////////////////////////////////////////
// Register map

`define EGRESS_APB_ADDR_W    8
`define EGRESS_APB_DATA_W    32
`define EGRESS_REG_ENABLE    8'h00
`define EGRESS_REG_CLEAR     8'h04
`define EGRESS_REG_PKT_BASE  8'h10
`define EGRESS_REG_DROP_BASE 8'h20
`define EGRESS_CNT_WIDTH     16

`endif

// ==== logic/egress_pkg.sv ====
/* Egress stage types */

`include "egress_config.svh"

package egress_pkg;

    //////////////////////////////////////////////////////////////////////
    // Port numbering

    typedef logic [$clog2(`EGRESS_NUM_PORTS)-1:0] port_id_t;
    typedef logic [`EGRESS_NUM_PORTS-1:0] port_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Stream beats

    // Input beat, byte 0 in the low bits goes out first
    typedef struct packed {
        logic [`EGRESS_WORD_BYTES*8-1:0] data;
        logic [`EGRESS_WORD_BYTES-1:0]   keep;
        logic                            last;
        // Only sampled on the first beat
        port_id_t                        dest;
    } egress_word_t;

    typedef struct packed {
        logic [`EGRESS_NARROW_BYTES*8-1:0] data;
        logic [`EGRESS_NARROW_BYTES-1:0]   keep;
        logic                              last;
    } lane8_t;

    typedef struct packed {
        logic [`EGRESS_WIDE_BYTES*8-1:0] data;
        logic [`EGRESS_WIDE_BYTES-1:0]   keep;
        logic                            last;
    } lane32_t;

    //////////////////////////////////////////////////////////////////////
    // APB

    typedef struct packed {
        logic                           psel;
        logic                           penable;
        logic                           pwrite;
        logic [`EGRESS_APB_ADDR_W-1:0]  paddr;
        logic [`EGRESS_APB_DATA_W-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`EGRESS_APB_DATA_W-1:0]  prdata;
        logic                           pready;
        logic                           pslverr;
    } apb_rsp_t;

endpackage

// ==== logic/egress_dispatch.sv ====
/* Packet dispatch to egress ports */

`include "egress_config.svh"

module egress_dispatch (
    input  logic                     core_clk_ifc,
    input  logic                     reset,

    input  egress_pkg::egress_word_t in_word,
    input  logic                     in_valid,
    output logic                     in_ready,

    input  egress_pkg::port_mask_t   enable,
    input  egress_pkg::port_mask_t   fifo_ready,
    output egress_pkg::egress_word_t fifo_word,
    output egress_pkg::port_mask_t   fifo_valid,
    output egress_pkg::port_mask_t   drop_pulse
);

    import egress_pkg::*;

    // Goes high one cycle after reset releases
    logic     accept_en;

    // Packet state, latched on the first beat
    logic     in_pkt;
    port_id_t cur_dest;
    logic     cur_drop;

    // Routing for the beat now on the input
    port_id_t sel_dest;
    logic     sel_drop;
    logic     beat_xfer;

    //////////////////////////////////////////////////////////////////////
    // Routing decision

    // First beat decides from its own dest and the live enable mask
    assign sel_dest = in_pkt ? cur_dest : in_word.dest;
    assign sel_drop = in_pkt ? cur_drop : ~enable[in_word.dest];

    // Dropped packets drain at full rate
    assign in_ready  = accept_en & (sel_drop | fifo_ready[sel_dest]);
    assign beat_xfer = in_valid & in_ready;

    // One word bus feeds every buffer, valid selects the target
    assign fifo_word = in_word;

    always_comb begin
        fifo_valid = '0;
        drop_pulse = '0;
        for (int p = 0; p < `EGRESS_NUM_PORTS; p++) begin
            if (sel_dest == port_id_t'(p)) begin
                fifo_valid[p] = in_valid & accept_en & ~sel_drop;
                drop_pulse[p] = beat_xfer & sel_drop & in_word.last;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Packet tracking

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            accept_en <= 1'b0;
            in_pkt    <= 1'b0;
            cur_dest  <= '0;
            cur_drop  <= 1'b0;
        end else begin
            accept_en <= 1'b1;
            if (beat_xfer) begin
                if (in_word.last) begin
                    in_pkt <= 1'b0;
                end else if (!in_pkt) begin
                    // Hold the decision until the last beat
                    in_pkt   <= 1'b1;
                    cur_dest <= in_word.dest;
                    cur_drop <= ~enable[in_word.dest];
                end
            end
        end
    end

endmodule

// ==== logic/egress_fifo.sv ====
/* Egress word buffer */

`include "egress_config.svh"

module egress_fifo (
    input  logic                     core_clk_ifc,
    input  logic                     reset,

    input  egress_pkg::egress_word_t wr_word,
    input  logic                     wr_valid,
    output logic                     wr_ready,

    output egress_pkg::egress_word_t rd_word,
    output logic                     rd_valid,
    input  logic                     rd_ready
);

    import egress_pkg::*;

    localparam int DEPTH = `EGRESS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    egress_word_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_wr;
    logic do_rd;

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_word  = mem[rd_ptr];

    assign do_wr = wr_valid & wr_ready;
    assign do_rd = rd_valid & rd_ready;

    // Storage
    always_ff @(posedge core_clk_ifc) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves count unchanged
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/egress_serializer.sv ====
/* Word to lane serializer */

`include "egress_config.svh"

module egress_serializer #(
    parameter type lane_t     = egress_pkg::lane8_t,
    parameter int  LANE_BYTES = 1
) (
    input  logic                     core_clk_ifc,
    input  logic                     reset,

    input  egress_pkg::egress_word_t word,
    input  logic                     word_valid,
    output logic                     word_ready,

    output lane_t                    out_lane,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import egress_pkg::*;

    localparam int LANES = `EGRESS_WORD_BYTES / LANE_BYTES;
    localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

    egress_word_t                  word_q;
    logic                          full;
    logic [IDX_W-1:0]              idx;

    logic [`EGRESS_WORD_BYTES-1:0] keep_rest;
    logic                          lane_final;
    logic                          lane_xfer;
    logic                          take;

    //////////////////////////////////////////////////////////////////////
    // Lane selection

    // Keep is packed from bit 0, so empty lanes only trail the word
    assign keep_rest  = word_q.keep >> ((int'(idx) + 1) * LANE_BYTES);
    assign lane_final = (int'(idx) == LANES - 1) || (keep_rest == '0);

    always_comb begin
        out_lane      = '0;
        out_lane.data = word_q.data[int'(idx)*LANE_BYTES*8 +: LANE_BYTES*8];
        out_lane.keep = word_q.keep[int'(idx)*LANE_BYTES +: LANE_BYTES];
        out_lane.last = word_q.last & lane_final;
    end

    assign out_valid  = full;
    assign lane_xfer  = out_valid & out_ready;

    // Refill as the final lane leaves, so words stream back to back
    assign word_ready = ~full | (lane_xfer & lane_final);
    assign take       = word_valid & word_ready;

    //////////////////////////////////////////////////////////////////////
    // State

    always_ff @(posedge core_clk_ifc) begin
        if (take) begin
            word_q <= word;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            full <= 1'b0;
            idx  <= '0;
        end else if (take) begin
            full <= 1'b1;
            idx  <= '0;
        end else if (lane_xfer) begin
            if (lane_final) begin
                full <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// ==== logic/egress_csr.sv ====
/* Egress APB registers */

`include "egress_config.svh"

module egress_csr (
    input  logic                   core_clk_ifc,
    input  logic                   reset,

    input  egress_pkg::apb_req_t   apb_req,
    output egress_pkg::apb_rsp_t   apb_rsp,

    input  egress_pkg::port_mask_t delivered,
    input  egress_pkg::port_mask_t drop_pulse,
    output egress_pkg::port_mask_t enable
);

    import egress_pkg::*;

    localparam int NP = `EGRESS_NUM_PORTS;
    localparam int CW = `EGRESS_CNT_WIDTH;

    logic [CW-1:0] pkt_cnt  [NP];
    logic [CW-1:0] drop_cnt [NP];

    logic                          access;
    logic                          wr_en;
    logic                          hit_enable;
    logic                          hit_clear;
    logic                          mapped;
    logic [`EGRESS_APB_DATA_W-1:0] rd_data;
    port_mask_t                    clr;

    //////////////////////////////////////////////////////////////////////
    // Decode

    assign access     = apb_req.psel & apb_req.penable;
    assign wr_en      = access & apb_req.pwrite;
    assign hit_enable = (apb_req.paddr == `EGRESS_REG_ENABLE);
    assign hit_clear  = (apb_req.paddr == `EGRESS_REG_CLEAR);

    assign clr = (wr_en && hit_clear) ? apb_req.pwdata[NP-1:0] : '0;

    always_comb begin
        rd_data = '0;
        mapped  = hit_enable | hit_clear;
        if (hit_enable) begin
            rd_data[NP-1:0] = enable;
        end
        // Count registers sit one word apart per port
        for (int p = 0; p < NP; p++) begin
            if (apb_req.paddr == 8'(`EGRESS_REG_PKT_BASE + 4 * p)) begin
                mapped          = 1'b1;
                rd_data[CW-1:0] = pkt_cnt[p];
            end
            if (apb_req.paddr == 8'(`EGRESS_REG_DROP_BASE + 4 * p)) begin
                mapped          = 1'b1;
                rd_data[CW-1:0] = drop_cnt[p];
            end
        end
    end

    // Zero wait states
    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & ~mapped;

    //////////////////////////////////////////////////////////////////////
    // Registers and counters

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            enable   <= '0;
            pkt_cnt  <= '{default: '0};
            drop_cnt <= '{default: '0};
        end else begin
            if (wr_en && hit_enable) begin
                enable <= apb_req.pwdata[NP-1:0];
            end
            for (int p = 0; p < NP; p++) begin
                // Clear wins over a same-cycle event
                if (clr[p]) begin
                    pkt_cnt[p]  <= '0;
                    drop_cnt[p] <= '0;
                end else begin
                    if (delivered[p] && pkt_cnt[p] != '1) begin
                        pkt_cnt[p] <= pkt_cnt[p] + 1'b1;
                    end
                    if (drop_pulse[p] && drop_cnt[p] != '1) begin
                        drop_cnt[p] <= drop_cnt[p] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/egress_top.sv ====
/* Router egress stage */

`include "egress_config.svh"

module egress_top (
    input  logic                     core_clk_ifc,
    input  logic                     reset,

    input  egress_pkg::egress_word_t in_word,
    input  logic                     in_valid,
    output logic                     in_ready,

    input  egress_pkg::apb_req_t     apb_req,
    output egress_pkg::apb_rsp_t     apb_rsp,

    output egress_pkg::lane8_t       narrow_lane  [`EGRESS_NUM_NARROW],
    output logic                     narrow_valid [`EGRESS_NUM_NARROW],
    input  logic                     narrow_ready [`EGRESS_NUM_NARROW],

    output egress_pkg::lane32_t      wide_lane  [`EGRESS_NUM_PORTS-`EGRESS_NUM_NARROW],
    output logic                     wide_valid [`EGRESS_NUM_PORTS-`EGRESS_NUM_NARROW],
    input  logic                     wide_ready [`EGRESS_NUM_PORTS-`EGRESS_NUM_NARROW]
);

    import egress_pkg::*;

    localparam int NN = `EGRESS_NUM_NARROW;
    localparam int NW = `EGRESS_NUM_PORTS - `EGRESS_NUM_NARROW;

    egress_word_t fifo_word;
    port_mask_t   fifo_valid;
    port_mask_t   fifo_ready;
    egress_word_t buf_word [`EGRESS_NUM_PORTS];
    port_mask_t   buf_valid;
    port_mask_t   buf_ready;
    port_mask_t   enable;
    port_mask_t   drop_pulse;
    port_mask_t   delivered;

    egress_dispatch u_dispatch (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .in_word      (in_word),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .enable       (enable),
        .fifo_ready   (fifo_ready),
        .fifo_word    (fifo_word),
        .fifo_valid   (fifo_valid),
        .drop_pulse   (drop_pulse)
    );

    for (genvar p = 0; p < `EGRESS_NUM_PORTS; p++) begin : g_fifo
        egress_fifo u_fifo (
            .core_clk_ifc (core_clk_ifc),
            .reset        (reset),
            .wr_word      (fifo_word),
            .wr_valid     (fifo_valid[p]),
            .wr_ready     (fifo_ready[p]),
            .rd_word      (buf_word[p]),
            .rd_valid     (buf_valid[p]),
            .rd_ready     (buf_ready[p])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Serializers, narrow ports first

    for (genvar i = 0; i < NN; i++) begin : g_narrow
        egress_serializer #(
            .lane_t     (lane8_t),
            .LANE_BYTES (`EGRESS_NARROW_BYTES)
        ) u_ser (
            .core_clk_ifc (core_clk_ifc),
            .reset        (reset),
            .word         (buf_word[i]),
            .word_valid   (buf_valid[i]),
            .word_ready   (buf_ready[i]),
            .out_lane     (narrow_lane[i]),
            .out_valid    (narrow_valid[i]),
            .out_ready    (narrow_ready[i])
        );
        // End of packet leaves the port
        assign delivered[i] = narrow_valid[i] & narrow_ready[i] & narrow_lane[i].last;
    end

    for (genvar j = 0; j < NW; j++) begin : g_wide
        egress_serializer #(
            .lane_t     (lane32_t),
            .LANE_BYTES (`EGRESS_WIDE_BYTES)
        ) u_ser (
            .core_clk_ifc (core_clk_ifc),
            .reset        (reset),
            .word         (buf_word[NN+j]),
            .word_valid   (buf_valid[NN+j]),
            .word_ready   (buf_ready[NN+j]),
            .out_lane     (wide_lane[j]),
            .out_valid    (wide_valid[j]),
            .out_ready    (wide_ready[j])
        );
        assign delivered[NN+j] = wide_valid[j] & wide_ready[j] & wide_lane[j].last;
    end

    egress_csr u_csr (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .delivered    (delivered),
        .drop_pulse   (drop_pulse),
        .enable       (enable)
    );

endmodule

// ==== verification/egress_tb.sv ====
/* Egress stage testbench */

`include "egress_config.svh"

module egress_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import egress_pkg::*;

    localparam int NP            = `EGRESS_NUM_PORTS;
    localparam int NN            = `EGRESS_NUM_NARROW;
    localparam int NW            = `EGRESS_NUM_PORTS - `EGRESS_NUM_NARROW;
    localparam int PKTS_PER_TEST = 60;
    localparam int TOTAL_PKTS    = 3 * PKTS_PER_TEST;
    localparam int TIMEOUT       = TOTAL_PKTS * `EGRESS_MTU_BYTES * 4 + 2000;
    // Outputs are sampled this long after the falling edge
    localparam int SETTLE        = 1;

    logic         core_clk_ifc;
    logic         reset;
    egress_word_t in_word;
    logic         in_valid;
    logic         in_ready;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    lane8_t       narrow_lane  [NN];
    logic         narrow_valid [NN];
    logic         narrow_ready [NN];
    lane32_t      wide_lane    [NW];
    logic         wide_valid   [NW];
    logic         wide_ready   [NW];

    // Reference model state
    logic [7:0] exp_bytes [NP][$];
    int         exp_len   [NP][$];
    int         pos       [NP];
    int         exp_pkt   [NP];
    int         exp_drop  [NP];
    port_mask_t model_en;

    integer seed;
    logic   ready_rand;
    int     cycles;
    int     errors;
    int     err_mark;
    int     pass_cnt;
    int     fail_cnt;

    egress_top DUT (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .in_word      (in_word),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .narrow_lane  (narrow_lane),
        .narrow_valid (narrow_valid),
        .narrow_ready (narrow_ready),
        .wide_lane    (wide_lane),
        .wide_valid   (wide_valid),
        .wide_ready   (wide_ready)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #4 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lane monitor

    task automatic check_lane(input int p, input int width, input logic [31:0] data,
                              input logic [3:0] keep, input logic last);
        int         remain;
        int         n;
        logic [3:0] exp_keep;
        logic [7:0] exp_byte;
        if (exp_len[p].size() == 0) begin
            $display("error at %0t: port %0d sent a lane while no packet was expected",
                     $time, p);
            errors++;
            return;
        end
        remain   = exp_len[p][0] - pos[p];
        n        = (remain < width) ? remain : width;
        exp_keep = 4'((1 << n) - 1);
        if (keep !== exp_keep) begin
            $display("mismatch at %0t: port %0d keep %b, expected %b", $time, p, keep, exp_keep);
            errors++;
        end
        if (last !== (remain <= width)) begin
            $display("mismatch at %0t: port %0d last %b, expected %b", $time, p, last,
                     remain <= width);
            errors++;
        end
        for (int b = 0; b < n; b++) begin
            exp_byte = exp_bytes[p].pop_front();
            if (data[b*8 +: 8] !== exp_byte) begin
                $display("mismatch at %0t: port %0d byte %0d is %h, expected %h", $time, p,
                         pos[p] + b, data[b*8 +: 8], exp_byte);
                errors++;
            end
        end
        pos[p] += n;
        if (remain <= width) begin
            exp_len[p].delete(0);
            pos[p] = 0;
        end
    endtask

    // Readies change on the falling edge, transfers are seen once settled
    always @(negedge core_clk_ifc) begin
        for (int i = 0; i < NN; i++) begin
            narrow_ready[i] = ready_rand ? 1'($random(seed)) : 1'b1;
        end
        for (int j = 0; j < NW; j++) begin
            wide_ready[j] = ready_rand ? 1'($random(seed)) : 1'b1;
        end
        #SETTLE;
        if (!reset) begin
            for (int i = 0; i < NN; i++) begin
                if (narrow_valid[i] && narrow_ready[i]) begin
                    check_lane(i, 1, 32'(narrow_lane[i].data), 4'(narrow_lane[i].keep),
                               narrow_lane[i].last);
                end
            end
            for (int j = 0; j < NW; j++) begin
                if (wide_valid[j] && wide_ready[j]) begin
                    check_lane(NN + j, 4, wide_lane[j].data, wide_lane[j].keep,
                               wide_lane[j].last);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge core_clk_ifc);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge core_clk_ifc);
        apb_req.penable = 1'b1;
        #SETTLE;
        while (!apb_rsp.pready) begin
            @(negedge core_clk_ifc);
            #SETTLE;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge core_clk_ifc);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic set_enable(input port_mask_t mask);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, `EGRESS_REG_ENABLE, 32'(mask), rd, err);
        model_en = mask;
        if (err) begin
            $display("error at %0t: write to the enable register was rejected", $time);
            errors++;
        end
    endtask

    task automatic send_packet(input int len, input port_id_t dest);
        logic [7:0]   pkt [$];
        egress_word_t w;
        int           nwords;
        for (int i = 0; i < len; i++) begin
            pkt.push_back(8'($random(seed)));
        end
        // Port state at packet start decides delivery or drop
        if (model_en[dest]) begin
            foreach (pkt[i]) exp_bytes[dest].push_back(pkt[i]);
            exp_len[dest].push_back(len);
            exp_pkt[dest]++;
        end else begin
            exp_drop[dest]++;
        end
        nwords = (len + 7) / 8;
        for (int wi = 0; wi < nwords; wi++) begin
            w      = '0;
            // Later beats carry junk dest, which must be ignored
            w.dest = (wi == 0) ? dest : port_id_t'($random(seed));
            w.last = (wi == nwords - 1);
            for (int b = 0; b < 8; b++) begin
                if (wi * 8 + b < len) begin
                    w.data[b*8 +: 8] = pkt[wi*8 + b];
                    w.keep[b]        = 1'b1;
                end
            end
            @(negedge core_clk_ifc);
            in_word  = w;
            in_valid = 1'b1;
            #SETTLE;
            while (!in_ready) begin
                @(negedge core_clk_ifc);
                #SETTLE;
            end
            @(posedge core_clk_ifc);
        end
        @(negedge core_clk_ifc);
        in_valid = 1'b0;
    endtask

    task automatic run_traffic(input int n);
        int       len;
        port_id_t dest;
        for (int k = 0; k < n; k++) begin
            @(posedge core_clk_ifc);
            len  = 1 + ($unsigned($random(seed)) % `EGRESS_MTU_BYTES);
            dest = port_id_t'($random(seed));
            send_packet(len, dest);
        end
    endtask

    task automatic wait_drain();
        int busy;
        do begin
            @(posedge core_clk_ifc);
            busy = 0;
            for (int p = 0; p < NP; p++) busy += exp_len[p].size();
        end while (busy != 0);
        repeat (4) @(posedge core_clk_ifc);
    endtask

    task automatic compare_counters();
        logic [31:0] rd;
        logic        err;
        for (int p = 0; p < NP; p++) begin
            apb_xfer(1'b0, 8'(`EGRESS_REG_PKT_BASE + 4 * p), '0, rd, err);
            if (err || rd !== 32'(exp_pkt[p])) begin
                $display("mismatch at %0t: packet count of port %0d reads %0d, expected %0d",
                         $time, p, rd, exp_pkt[p]);
                errors++;
            end
            apb_xfer(1'b0, 8'(`EGRESS_REG_DROP_BASE + 4 * p), '0, rd, err);
            if (err || rd !== 32'(exp_drop[p])) begin
                $display("mismatch at %0t: drop count of port %0d reads %0d, expected %0d",
                         $time, p, rd, exp_drop[p]);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] rd;
        logic        err;
        seed       = 20;
        cycles     = 0;
        errors     = 0;
        err_mark   = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        ready_rand = 1'b0;
        model_en   = '0;
        reset      = 1'b1;
        in_word    = '0;
        in_valid   = 1'b0;
        apb_req    = '0;
        for (int i = 0; i < NN; i++) narrow_ready[i] = 1'b1;
        for (int j = 0; j < NW; j++) wide_ready[j] = 1'b1;
        for (int p = 0; p < NP; p++) begin
            pos[p]      = 0;
            exp_pkt[p]  = 0;
            exp_drop[p] = 0;
        end
        repeat (10) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        reset = 1'b0;

        // Enables come out of reset off
        apb_xfer(1'b0, `EGRESS_REG_ENABLE, '0, rd, err);
        if (rd !== 32'h0) begin
            $display("mismatch at %0t: enable reads %h after reset, expected 0", $time, rd);
            errors++;
        end
        set_enable(4'hf);
        run_traffic(PKTS_PER_TEST);
        wait_drain();
        end_test("1 all ports, full rate");

        ready_rand = 1'b1;
        run_traffic(PKTS_PER_TEST);
        wait_drain();
        end_test("2 random back-pressure");

        set_enable(4'b0101);
        run_traffic(PKTS_PER_TEST);
        wait_drain();
        end_test("3 ports 1 and 3 disabled");

        compare_counters();
        apb_xfer(1'b1, `EGRESS_REG_CLEAR, 32'h6, rd, err);
        exp_pkt[1]  = 0;
        exp_drop[1] = 0;
        exp_pkt[2]  = 0;
        exp_drop[2] = 0;
        compare_counters();
        end_test("4 counters and clear");

        apb_xfer(1'b0, 8'h08, '0, rd, err);
        if (err !== 1'b1) begin
            $display("mismatch at %0t: read of unmapped 0x08 gave pslverr %b", $time, err);
            errors++;
        end
        apb_xfer(1'b1, 8'h44, 32'hffff, rd, err);
        if (err !== 1'b1) begin
            $display("mismatch at %0t: write to unmapped 0x44 gave pslverr %b", $time, err);
            errors++;
        end
        set_enable(4'b1010);
        apb_xfer(1'b0, `EGRESS_REG_ENABLE, '0, rd, err);
        if (err !== 1'b0 || rd !== 32'h0000000a) begin
            $display("mismatch at %0t: enable reads %h err %b, expected a", $time, rd, err);
            errors++;
        end
        end_test("5 unmapped access and enable readback");

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/egress_pkg.sv
logic/egress_dispatch.sv
logic/egress_fifo.sv
logic/egress_serializer.sv
logic/egress_csr.sv
logic/egress_top.sv
verification/egress_tb.sv

// ==== Bender.yml ====
package:
  name: egress

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/egress_pkg.sv
      - logic/egress_dispatch.sv
      - logic/egress_fifo.sv
      - logic/egress_serializer.sv
      - logic/egress_csr.sv
      - logic/egress_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/egress_tb.sv
